// ==== hw/arbCtrl.sv ====
module arbCtrl
    import memBusPkg::*;
    import arbPkg::*;
(
    input  logic            accelWrBlkDone,   // clock
    input  logic            accelRdBlkDone,   // async reset, active high
    input  logic            halt,             // no new grants while high
    input  logic            instrReq,
    input  logic            dataRdReq,
    input  logic            dataEvictReq,
    input  logic            accelRd,
    input  logic            accelWr,
    input  logic            memTxDone,
    input  logic            memRdValid,
    input  logic            lastBlk,          // accel offset sits on the end entry
    output memBusPkg::memOp memOp,
    output grantSel         grant,
    output logic            blkStart,
    output logic            blkDone,
    output logic            capture
);

    arbState         state;
    logic            coolDown;   // client pulse cycle, requests still stale
    logic            inSig;      // a signal stream is open
    logic            grantNow;
    logic            txEnd;      // final edge of the current transfer
    grantSel         pick;
    memBusPkg::memOp pickOp;

    // fixed priority, instr > data > accel
    always_comb begin
        pick   = grNone;
        pickOp = memIdle;
        if (instrReq) begin
            pick   = grInstr;
            pickOp = memRead;
        end else if (dataEvictReq) begin    // evict before refill
            pick   = grData;
            pickOp = memWrite;
        end else if (dataRdReq) begin
            pick   = grData;
            pickOp = memRead;
        end else if (accelRd) begin
            pick   = grAccel;
            pickOp = memRead;
        end else if (accelWr) begin
            pick   = grAccel;
            pickOp = memWrite;
        end
    end

    assign grantNow = (state == stIdle) && !halt && !coolDown && (pick != grNone);
    assign blkStart = grantNow && (pick == grAccel) && !inSig;   // first block of a signal

    // read data lands either with tx done or later in stWait
    assign capture = memRdValid &&
                     ((state == stWait) ||
                      ((state == stReq) && (memOp == memRead) && memTxDone));
    assign txEnd   = capture || ((state == stReq) && (memOp == memWrite) && memTxDone);

    // grant is still held during the pulse cycle
    assign blkDone = coolDown && (grant == grAccel);

    always_ff @(posedge accelWrBlkDone or posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            state    <= stIdle;
            memOp    <= memIdle;
            grant    <= grNone;
            coolDown <= 1'b0;
            inSig    <= 1'b0;
        end else begin
            coolDown <= txEnd;
            if (blkDone && lastBlk) begin
                inSig <= 1'b0;   // stream finished, next grant reloads
            end else if (blkStart) begin
                inSig <= 1'b1;
            end
            case (state)
                stIdle: begin
                    if (!coolDown) begin
                        grant <= grantNow ? pick : grNone;
                    end
                    if (grantNow) begin
                        memOp <= pickOp;   // op goes out the cycle after grant
                        state <= stReq;
                    end
                end
                stReq: begin
                    if (memTxDone) begin
                        memOp <= memIdle;
                        if ((memOp == memRead) && !memRdValid) begin
                            state <= stWait;   // data comes later
                        end else begin
                            state <= stIdle;
                        end
                    end
                end
                stWait: begin
                    if (memRdValid) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// ==== hw/arbPkg.sv ====
package arbPkg;

    // current owner of the memory port
    typedef enum logic [1:0] {
        grNone  = 2'b00,
        grInstr = 2'b01,
        grData  = 2'b10,
        grAccel = 2'b11
    } grantSel;

    // controller phases
    typedef enum logic [1:0] {
        stIdle = 2'b00,   // sample requests
        stReq  = 2'b01,   // op on the port, waiting for tx done
        stWait = 2'b10    // read accepted, waiting for data
    } arbState;

    localparam int OffBits = 18;   // block offset inside one signal

    // signal table entry, start offset low, end offset high
    localparam int EntStartLo = 0;
    localparam int EntEndLo   = OffBits;
    localparam int EntBits    = 2 * OffBits;

endpackage

// ==== hw/blkRouter.sv ====
module blkRouter
    import memBusPkg::*;
    import arbPkg::*;
(
    input  logic               accelWrBlkDone,   // clock
    input  logic               accelRdBlkDone,   // async reset
    input  grantSel            grant,
    input  logic               capture,          // read data valid this edge
    input  logic               memTxDone,
    input  memBusPkg::memOp    memOp,
    input  logic [BlkBits-1:0] memRdData,
    input  logic [BlkBits-1:0] dataWrBlk,
    input  logic [BlkBits-1:0] accelWrBlkData,
    output logic [BlkBits-1:0] memWrData,
    output logic [BlkBits-1:0] instrBlk,
    output logic               instrValid,
    output logic [BlkBits-1:0] dataBlk,
    output logic               dataRdValid,
    output logic               dataEvictAck,
    output logic [BlkBits-1:0] accelBlk,
    output logic               accelRdBlk,
    output logic               accelWrBlk
);

    logic wrEnd;

    // instr cache never writes
    always_comb begin
        case (grant)
            grData:  memWrData = dataWrBlk;
            grAccel: memWrData = accelWrBlkData;
            default: memWrData = '0;
        endcase
    end

    assign wrEnd = memTxDone && (memOp == memWrite);   // op only active in stReq

    // holding regs, block stays put until the next read for that client
    always_ff @(posedge accelWrBlkDone) begin
        if (capture) begin
            case (grant)
                grInstr: instrBlk <= memRdData;
                grData:  dataBlk  <= memRdData;
                grAccel: accelBlk <= memRdData;
                default: ;
            endcase
        end
    end

    // one cycle pulses, line up with the holding regs
    always_ff @(posedge accelWrBlkDone or posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            instrValid   <= 1'b0;
            dataRdValid  <= 1'b0;
            accelRdBlk   <= 1'b0;
            dataEvictAck <= 1'b0;
            accelWrBlk   <= 1'b0;
        end else begin
            instrValid   <= capture && (grant == grInstr);
            dataRdValid  <= capture && (grant == grData);
            accelRdBlk   <= capture && (grant == grAccel);
            dataEvictAck <= wrEnd && (grant == grData);
            accelWrBlk   <= wrEnd && (grant == grAccel);
        end
    end

endmodule

// ==== hw/memArbTop.sv ====
module memArbTop
    import memBusPkg::*;
    import arbPkg::*;
#(
    parameter int SigIdxBits = 8
) (
    input  logic                  accelWrBlkDone,   // clock
    input  logic                  accelRdBlkDone,   // async reset, active high
    input  logic                  halt,
    input  logic                  instrReq,         // instr cache miss
    input  logic [AddrBits-1:0]   instrAddr,
    output logic [BlkBits-1:0]    instrBlk,
    output logic                  instrValid,
    input  logic                  dataRdReq,        // data cache miss
    input  logic                  dataEvictReq,
    input  logic [AddrBits-1:0]   dataAddr,
    input  logic [BlkBits-1:0]    dataWrBlk,        // victim block
    output logic [BlkBits-1:0]    dataBlk,
    output logic                  dataRdValid,
    output logic                  dataEvictAck,
    input  logic                  accelRd,          // fill accel buffer
    input  logic                  accelWr,          // drain accel buffer
    input  logic [SigIdxBits-1:0] sigNum,
    input  logic [BlkBits-1:0]    accelWrBlkData,
    output logic [BlkBits-1:0]    accelBlk,
    output logic                  accelRdBlk,
    output logic                  accelWrBlk,
    output logic                  accelXferDone,    // with the last block of a signal
    input  logic                  sigTblWr,
    input  logic [SigIdxBits-1:0] sigTblIdx,
    input  logic [OffBits-1:0]    sigTblStart,
    input  logic [OffBits-1:0]    sigTblEnd,
    output memBusPkg::memOp       memOp,
    output memBusPkg::memAddr     memAddr,
    output logic [BlkBits-1:0]    memWrData,
    input  logic [BlkBits-1:0]    memRdData,
    input  logic                  memTxDone,
    input  logic                  memRdValid
);

    grantSel           grant;
    logic              blkStart;
    logic              blkDone;
    logic              capture;
    logic              lastBlk;
    memBusPkg::memAddr accelAddr;

    arbCtrl ctrl0 (
        .accelWrBlkDone(accelWrBlkDone), .accelRdBlkDone(accelRdBlkDone), .halt(halt),
        .instrReq(instrReq), .dataRdReq(dataRdReq), .dataEvictReq(dataEvictReq),
        .accelRd(accelRd), .accelWr(accelWr), .memTxDone(memTxDone),
        .memRdValid(memRdValid), .lastBlk(lastBlk), .memOp(memOp), .grant(grant),
        .blkStart(blkStart), .blkDone(blkDone), .capture(capture)
    );

    sigAddrGen #(.SigIdxBits(SigIdxBits)) addr0 (
        .accelWrBlkDone(accelWrBlkDone), .accelRdBlkDone(accelRdBlkDone), .sigNum(sigNum),
        .sigTblWr(sigTblWr), .sigTblIdx(sigTblIdx), .sigTblStart(sigTblStart),
        .sigTblEnd(sigTblEnd), .blkStart(blkStart), .blkDone(blkDone),
        .accelAddr(accelAddr), .lastBlk(lastBlk)
    );

    blkRouter route0 (
        .accelWrBlkDone(accelWrBlkDone), .accelRdBlkDone(accelRdBlkDone), .grant(grant),
        .capture(capture), .memTxDone(memTxDone), .memOp(memOp), .memRdData(memRdData),
        .dataWrBlk(dataWrBlk), .accelWrBlkData(accelWrBlkData), .memWrData(memWrData),
        .instrBlk(instrBlk), .instrValid(instrValid), .dataBlk(dataBlk),
        .dataRdValid(dataRdValid), .dataEvictAck(dataEvictAck), .accelBlk(accelBlk),
        .accelRdBlk(accelRdBlk), .accelWrBlk(accelWrBlk)
    );

    // address follows the grant, held until the next grant
    assign memAddr.flat = (grant == grAccel) ? accelAddr.flat :
                          (grant == grData)  ? dataAddr : instrAddr;

    // offset still on the finished block during the done cycle
    assign accelXferDone = blkDone && lastBlk;

endmodule

// ==== hw/memBusPkg.sv ====
package memBusPkg;

    // host memory port operation, encoding kept from the old controller
    typedef enum logic [1:0] {
        memIdle  = 2'b00,
        memRead  = 2'b01,
        memWrite = 2'b11
    } memOp;

    localparam int BlkBits = 512;        // one memory word is one cache block

    localparam int AddrBits    = 32;
    localparam int RegionBits  = 4;
    localparam int BlkIdxBits  = 22;
    localparam int ByteOffBits = 6;      // 64 bytes per block

    localparam logic [RegionBits-1:0] AccelRegion = 4'h1;   // signal data lives here

    // byte address, seen flat or split into region / block / byte
    typedef union packed {
        logic [AddrBits-1:0] flat;
        struct packed {
            logic [RegionBits-1:0]  region;
            logic [BlkIdxBits-1:0]  blkIdx;
            logic [ByteOffBits-1:0] byteOff;
        } f;
    } memAddr;

endpackage

// ==== hw/sigAddrGen.sv ====
module sigAddrGen
    import memBusPkg::*;
    import arbPkg::*;
#(
    parameter int SigIdxBits = 8
) (
    input  logic                  accelWrBlkDone,   // clock
    input  logic                  accelRdBlkDone,   // async reset
    input  logic [SigIdxBits-1:0] sigNum,
    input  logic                  sigTblWr,
    input  logic [SigIdxBits-1:0] sigTblIdx,
    input  logic [OffBits-1:0]    sigTblStart,
    input  logic [OffBits-1:0]    sigTblEnd,
    input  logic                  blkStart,
    input  logic                  blkDone,
    output memBusPkg::memAddr     accelAddr,
    output logic                  lastBlk
);

    localparam int SigCnt = 1 << SigIdxBits;

    logic [EntBits-1:0] sigTbl [SigCnt];   // start and end offset per signal
    logic [EntBits-1:0] curEnt;
    logic [OffBits-1:0] blkOff;            // running block offset

    // table port, separate from the arbiter path
    always_ff @(posedge accelWrBlkDone) begin
        if (sigTblWr) begin
            sigTbl[sigTblIdx][EntStartLo +: OffBits] <= sigTblStart;
            sigTbl[sigTblIdx][EntEndLo +: OffBits]   <= sigTblEnd;
        end
    end

    assign curEnt  = sigTbl[sigNum];
    assign lastBlk = (blkOff == curEnt[EntEndLo +: OffBits]);   // end is inclusive

    // on the last block the offset holds and waits for the next blkStart
    always_ff @(posedge accelWrBlkDone or posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            blkOff <= '0;
        end else if (blkStart) begin
            blkOff <= curEnt[EntStartLo +: OffBits];
        end else if (blkDone && !lastBlk) begin
            blkOff <= blkOff + 1'b1;
        end
    end

    // block aligned address in the accel region
    always_comb begin
        accelAddr.f.region  = AccelRegion;
        accelAddr.f.blkIdx  = BlkIdxBits'(blkOff);
        accelAddr.f.byteOff = '0;
    end

endmodule

// ==== list.f ====
hw/memBusPkg.sv
hw/arbPkg.sv
hw/arbCtrl.sv
hw/sigAddrGen.sv
hw/blkRouter.sv
hw/memArbTop.sv
testbench/memModel.sv
testbench/memArbTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the memory arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module memArbTb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== testbench/arbCases.txt ====
# columns: op, address or signal number (hex), table start, table end (hex),
# write seed (hex), expected completion order (I instr, D data read, E evict, A accel)
# ops: ir dr de dboth ar aw mix midsig halt
ir     00002000 0 0 00000000 I
ir     00abc040 0 0 00000000 I
dr     00003100 0 0 00000000 D
dr     0f0000c0 0 0 00000000 D
de     00004400 0 0 1234abcd E
de     00007f80 0 0 0badf00d E
dboth  00005000 0 0 5555aaaa ED
dboth  00006240 0 0 77778888 ED
ar     00000003 a c 00000000 AAA
ar     00000007 0 0 00000000 A
ar     00000011 3fff0 3fff3 00000000 AAAA
aw     00000004 14 17 9e3779b9 AAAA
aw     00000022 100 100 cafe1234 A
mix    00000009 5 6 00000000 IDAA
mix    00000031 40 42 00000000 IDAAA
midsig 0000000a 1e 20 00000000 AIAA
midsig 00000044 2 5 00000000 AIAAA
halt   00006000 0 0 00000000 ID
halt   00008880 0 0 00000000 ID

// ==== testbench/memArbTb.sv ====
module memArbTb
    import memBusPkg::*;
    import arbPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic accelWrBlkDone, accelRdBlkDone, halt;
    logic instrReq, dataRdReq, dataEvictReq, accelRd, accelWr, sigTblWr;
    logic [31:0] instrAddr, dataAddr;
    logic [7:0]  sigNum, sigTblIdx;
    logic [OffBits-1:0] sigTblStart, sigTblEnd;
    logic [BlkBits-1:0] dataWrBlk, accelWrBlkData, instrBlk, dataBlk, accelBlk;
    logic [BlkBits-1:0] memWrData, memRdData;
    logic instrValid, dataRdValid, dataEvictAck, accelRdBlk, accelWrBlk, accelXferDone;
    logic memTxDone, memRdValid;
    memBusPkg::memOp   memOp;
    memBusPkg::memAddr memAddr;
    string opQ[$], ordQ[$];
    logic [31:0] aQ[$], sQ[$], eQ[$], seedQ[$];
    int nCases = 0;
    int errCnt = 0;
    int failCnt = 0;

    memArbTop #(.SigIdxBits(8)) dut0 (.*);
    memModel mem0 (.*);

    initial begin
        accelWrBlkDone = 1'b0;
        forever #50 accelWrBlkDone = ~accelWrBlkDone;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [BlkBits-1:0] makeBlk(input logic [31:0] seed);
        logic [BlkBits-1:0] b;
        logic [31:0] x;
        x = seed | 32'h1;   // xorshift stalls on zero
        for (int i = 0; i < BlkBits / 32; i++) begin
            x = xorshift(x);
            b[i*32 +: 32] = x;
        end
        return b;
    endfunction

    function automatic logic [BlkBits-1:0] expRdBlk(input logic [31:0] a);
        logic [BlkBits-1:0] b;
        for (int i = 0; i < BlkBits / 32; i++) begin
            b[i*32 +: 32] = a + 32'(i);
        end
        return b;
    endfunction

    task automatic expectEq(input logic [BlkBits-1:0] got, exp, input string what);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got[63:0], exp[63:0]);
            errCnt++;
        end
    endtask

    task automatic stepCycle();
        @(posedge accelWrBlkDone);
        #10;   // drive and sample away from the edge
    endtask

    task automatic runCase(input int idx, input string op, input logic [31:0] a, s, e, seed,
                           input string expOrd);
        string got;
        int nAcc, xfer, nBlk, errs0, wr0, nWr;
        logic [31:0] accAddr;
        errs0 = errCnt;
        wr0 = mem0.wrCnt;
        nWr = 0;
        got = "";
        nAcc = 0;
        xfer = 0;
        nBlk = int'(e) - int'(s) + 1;   // end offset is inclusive
        stepCycle();
        instrAddr = a;
        dataAddr = a ^ 32'h0000_1000;
        sigNum = a[7:0];
        dataWrBlk = makeBlk(seed);
        accelWrBlkData = makeBlk(~seed);
        sigTblWr = 1'b1;   // load the table entry for this signal
        sigTblIdx = a[7:0];
        sigTblStart = s[OffBits-1:0];
        sigTblEnd = e[OffBits-1:0];
        stepCycle();
        sigTblWr = 1'b0;
        halt = (op == "halt");
        instrReq = (op == "ir" || op == "mix" || op == "halt");
        dataRdReq = (op == "dr" || op == "dboth" || op == "mix" || op == "halt");
        dataEvictReq = (op == "de" || op == "dboth");
        accelRd = (op == "ar" || op == "mix" || op == "midsig");
        accelWr = (op == "aw");
        if (halt) begin
            repeat (10) begin
                stepCycle();
                assert (memOp == memIdle && !instrValid && !dataRdValid && !dataEvictAck &&
                        !accelRdBlk && !accelWrBlk) else begin
                    $display("halt: memory operation or done pulse seen at %0t", $time);
                    errCnt++;
                end
            end
            halt = 1'b0;
        end
        while (instrReq || dataRdReq || dataEvictReq || accelRd || accelWr) begin
            stepCycle();
            accAddr = {AccelRegion, 22'(s + 32'(nAcc)), 6'h0};
            if (dataEvictAck) begin
                got = {got, "E"};
                expectEq(BlkBits'(mem0.lastWrAddr), BlkBits'(dataAddr), "evict addr");
                expectEq(mem0.lastWrData, dataWrBlk, "evict data");
                dataEvictReq = 1'b0;
            end
            if (instrValid) begin
                got = {got, "I"};
                expectEq(instrBlk, expRdBlk(instrAddr), "instr block");
                instrReq = 1'b0;
            end
            if (dataRdValid) begin
                got = {got, "D"};
                expectEq(dataBlk, expRdBlk(dataAddr), "data block");
                dataRdReq = 1'b0;
            end
            if (accelRdBlk || accelWrBlk) begin
                got = {got, "A"};
                if (accelRdBlk) expectEq(accelBlk, expRdBlk(accAddr), "accel rd block");
                if (accelWrBlk) begin
                    expectEq(BlkBits'(mem0.lastWrAddr), BlkBits'(accAddr), "accel wr addr");
                    expectEq(mem0.lastWrData, accelWrBlkData, "accel wr data");
                    accelWrBlkData = makeBlk(accelWrBlkData[31:0]);   // new block each time
                end
                nAcc++;
            end
            if (accelXferDone) begin
                xfer++;
                assert (nAcc == nBlk) else begin
                    $display("mismatch at %0t: xfer done after %0d of %0d blocks",
                             $time, nAcc, nBlk);
                    errCnt++;
                end
                accelRd = 1'b0;
                accelWr = 1'b0;
            end
            if (op == "midsig" && got.len() == 1) instrReq = 1'b1;   // cut into the stream
        end
        assert (got == expOrd) else begin
            $display("mismatch at %0t: order %s expected %s", $time, got, expOrd);
            errCnt++;
        end
        // evictions and accel write blocks each land once in memory
        for (int i = 0; i < expOrd.len(); i++) begin
            if (expOrd.getc(i) == "E" || (op == "aw" && expOrd.getc(i) == "A")) nWr++;
        end
        assert (mem0.wrCnt == wr0 + nWr) else begin
            $display("mismatch at %0t: %0d memory writes expected %0d",
                     $time, mem0.wrCnt - wr0, nWr);
            errCnt++;
        end
        if (nAcc > 0) begin
            assert (xfer == 1) else begin
                $display("accel transfer done pulsed %0d times instead of once", xfer);
                errCnt++;
            end
        end
        if (errCnt != errs0) failCnt++;
        $display("test %0d %s: %s", idx, op, (errCnt == errs0) ? "ok" : "bad");
    endtask

    initial begin
        wait (nCases > 0);
        repeat (nCases * 400) @(posedge accelWrBlkDone);
        $display("watchdog: run did not finish within %0d cycles", nCases * 400);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int fd, n;
        string line, op, ord;
        logic [31:0] a, s, e, seed;
        {halt, instrReq, dataRdReq, dataEvictReq, accelRd, accelWr, sigTblWr} = '0;
        {instrAddr, dataAddr, sigNum, sigTblIdx, sigTblStart, sigTblEnd} = '0;
        dataWrBlk = '0;
        accelWrBlkData = '0;
        accelRdBlkDone = 1'b1;
        fd = $fopen("testbench/arbCases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file testbench/arbCases.txt");
            errCnt++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n == 0) break;   // nothing left to read
                if (line.len() < 3 || line.getc(0) == "#") continue;   // comment or blank
                n = $sscanf(line, "%s %h %h %h %h %s", op, a, s, e, seed, ord);
                if (n != 6) continue;
                opQ.push_back(op);
                aQ.push_back(a);
                sQ.push_back(s);
                eQ.push_back(e);
                seedQ.push_back(seed);
                ordQ.push_back(ord);
            end
            $fclose(fd);
            nCases = opQ.size();
        end
        repeat (4) @(posedge accelWrBlkDone);
        #10 accelRdBlkDone = 1'b0;
        assert (memOp == memIdle && !instrValid && !dataRdValid && !dataEvictAck &&
                !accelRdBlk && !accelWrBlk && !accelXferDone) else begin
            $display("outputs not idle after reset");
            errCnt++;
        end
        if (nCases == 0) begin
            $display("no test cases were read");
            errCnt++;
        end
        for (int i = 0; i < nCases; i++) begin
            runCase(i, opQ[i], aQ[i], sQ[i], eQ[i], seedQ[i], ordQ[i]);
        end
        $display("tests %0d, failed %0d, errors %0d", nCases, failCnt, errCnt);
        if (errCnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/memModel.sv ====
module memModel
    import memBusPkg::*;
(
    input  logic                accelWrBlkDone,   // clock
    input  logic                accelRdBlkDone,   // async reset
    input  memBusPkg::memOp     memOp,
    input  memBusPkg::memAddr   memAddr,
    input  logic [BlkBits-1:0]  memWrData,
    output logic [BlkBits-1:0]  memRdData,
    output logic                memTxDone,
    output logic                memRdValid
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        busy;
    logic        lateRd;                 // this read returns data after tx done
    logic        rdPend;                 // tx done sent, data due next cycle
    logic [1:0]  cnt;                    // cycles left before tx done
    logic [31:0] rnd;
    logic [31:0] lastWrAddr;             // write log, read by the testbench
    logic [BlkBits-1:0] lastWrData;
    int          wrCnt;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // every 32-bit lane holds address plus lane index
    function automatic logic [BlkBits-1:0] laneBlk(input logic [31:0] a);
        logic [BlkBits-1:0] b;
        for (int i = 0; i < BlkBits / 32; i++) begin
            b[i*32 +: 32] = a + 32'(i);
        end
        return b;
    endfunction

    always @(posedge accelWrBlkDone or posedge accelRdBlkDone) begin
        if (accelRdBlkDone) begin
            memTxDone  <= 1'b0;
            memRdValid <= 1'b0;
            memRdData  <= '0;
            busy       <= 1'b0;
            lateRd     <= 1'b0;
            rdPend     <= 1'b0;
            cnt        <= '0;
            rnd        <= 32'h4395_8235;
            lastWrAddr <= '0;
            lastWrData <= '0;
            wrCnt      <= 0;
        end else begin
            memTxDone  <= 1'b0;
            memRdValid <= 1'b0;
            rdPend     <= 1'b0;
            if (rdPend) begin
                memRdValid <= 1'b1;   // address still held while the arbiter waits
                memRdData  <= laneBlk(memAddr.flat);
            end
            if (busy) begin
                if (cnt == 2'd0) begin
                    busy      <= 1'b0;
                    memTxDone <= 1'b1;
                    if (memOp == memRead) begin
                        if (lateRd) begin
                            rdPend <= 1'b1;   // data one cycle after tx done
                        end else begin
                            memRdValid <= 1'b1;   // data with tx done
                            memRdData  <= laneBlk(memAddr.flat);
                        end
                    end else begin
                        lastWrAddr <= memAddr.flat;
                        lastWrData <= memWrData;
                        wrCnt      <= wrCnt + 1;
                    end
                end else begin
                    cnt <= cnt - 2'd1;
                end
            end else if (memOp != memIdle && !memTxDone) begin
                busy   <= 1'b1;   // new op, pick a delay of 0 to 3
                rnd    <= xorshift(rnd);
                cnt    <= rnd[1:0];
                lateRd <= rnd[2];
            end
        end
    end

endmodule
